// File: core_bus_pkg.sv
package core_bus_pkg;

    // Word addressed, one word per access
    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 32;
    localparam int CORE_TAG_W = 4;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [CORE_TAG_W-1:0] core_tag_t;

    // Instruction fetch request
    typedef struct packed {
        addr_t     addr;
        core_tag_t tag;
    } icache_req_t;

    // Response to the core on both paths
    typedef struct packed {
        data_t     data;
        core_tag_t tag;
    } core_rsp_t;

    // Data request, whole word writes
    typedef struct packed {
        logic      write;
        addr_t     addr;
        data_t     data;
        core_tag_t tag;
    } dcache_req_t;

endpackage

// File: mem_bus_pkg.sv
package mem_bus_pkg;

    // Source codes in the top bit of the memory tag
    localparam logic SRC_ICACHE = 1'b0;
    localparam logic SRC_DATA   = 1'b1;

    // Line index field is as wide as a core tag so both tag views line up
    localparam int LINE_W = core_bus_pkg::CORE_TAG_W;

    // Instruction cache view, unused upper line bits are zero
    typedef struct packed {
        logic              src;
        logic [LINE_W-1:0] line;
    } icache_mem_tag_t;

    // Data path view
    typedef struct packed {
        logic                   src;
        core_bus_pkg::core_tag_t tag;
    } data_mem_tag_t;

    typedef union packed {
        icache_mem_tag_t icache;
        data_mem_tag_t   data;
    } mem_tag_t;

    typedef struct packed {
        logic                write;
        core_bus_pkg::addr_t addr;
        core_bus_pkg::data_t data;
        mem_tag_t            tag;
    } mem_req_t;

    typedef struct packed {
        core_bus_pkg::data_t data;
        mem_tag_t            tag;
    } mem_rsp_t;

endpackage

// File: icache.sv
`timescale 1ns/100ps

module icache #(
    parameter int ICACHE_LINES = 16
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      icache_req_valid,
    input  core_bus_pkg::icache_req_t icache_req,
    output logic                      icache_req_ready,
    output logic                      icache_rsp_valid,
    output core_bus_pkg::core_rsp_t   icache_rsp,
    input  logic                      icache_rsp_ready,
    output logic                      mem_req_valid,
    output mem_bus_pkg::mem_req_t     mem_req,
    input  logic                      mem_req_ready,
    input  logic                      mem_rsp_valid,
    input  mem_bus_pkg::mem_rsp_t     mem_rsp,
    output logic                      mem_rsp_ready
);

    localparam int IDX_W = $clog2(ICACHE_LINES);
    localparam int TAG_W = core_bus_pkg::ADDR_W - IDX_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_MISS,
        S_RSP
    } state_t;

    state_t                    state;
    logic                      req_sent;
    logic [ICACHE_LINES-1:0]   line_valid;
    logic [TAG_W-1:0]          tag_arr [ICACHE_LINES];
    core_bus_pkg::data_t       data_arr [ICACHE_LINES];
    core_bus_pkg::icache_req_t req_q;
    core_bus_pkg::data_t       rsp_data;

    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] fill_idx;
    logic             hit;
    logic             req_fire;
    logic             mem_req_fire;
    logic             mem_rsp_fire;

    assign req_idx  = icache_req.addr[IDX_W-1:0];
    assign req_tag  = icache_req.addr[core_bus_pkg::ADDR_W-1:IDX_W];
    assign hit      = line_valid[req_idx] && (tag_arr[req_idx] == req_tag);
    // Fill line comes back in the memory tag
    assign fill_idx = mem_rsp.tag.icache.line[IDX_W-1:0];

    assign icache_req_ready = (state == S_IDLE);
    assign icache_rsp_valid = (state == S_RSP);
    assign icache_rsp       = '{data: rsp_data, tag: req_q.tag};

    assign mem_req_valid = (state == S_MISS) && !req_sent;
    assign mem_rsp_ready = (state == S_MISS) && req_sent;

    assign req_fire     = icache_req_valid && icache_req_ready;
    assign mem_req_fire = mem_req_valid && mem_req_ready;
    assign mem_rsp_fire = mem_rsp_valid && mem_rsp_ready;

    always_comb begin
        mem_req                            = '0;
        mem_req.addr                       = req_q.addr;
        mem_req.tag.icache.src             = mem_bus_pkg::SRC_ICACHE;
        mem_req.tag.icache.line[IDX_W-1:0] = req_q.addr[IDX_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            req_sent   <= 1'b0;
            line_valid <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req_fire) begin
                        state <= hit ? S_RSP : S_MISS;
                    end
                end
                S_MISS: begin
                    if (mem_req_fire) begin
                        req_sent <= 1'b1;
                    end
                    if (mem_rsp_fire) begin
                        req_sent             <= 1'b0;
                        line_valid[fill_idx] <= 1'b1;
                        state                <= S_RSP;
                    end
                end
                S_RSP: begin
                    if (icache_rsp_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_q    <= icache_req;
            rsp_data <= data_arr[req_idx];
        end
        // Fill and forward the word in the same cycle
        if (mem_rsp_fire) begin
            tag_arr[fill_idx]  <= req_q.addr[core_bus_pkg::ADDR_W-1:IDX_W];
            data_arr[fill_idx] <= mem_rsp.data;
            rsp_data           <= mem_rsp.data;
        end
    end

    // Memory only answers a read this cache has issued
    assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid |-> (state == S_MISS) && req_sent)
        else $error("icache: memory response without a pending miss");

endmodule

// File: shared_mem.sv
`timescale 1ns/100ps

module shared_mem #(
    parameter int SMEM_WORDS = 64
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req_valid,
    input  core_bus_pkg::dcache_req_t req,
    output logic                      req_ready,
    output logic                      rsp_valid,
    output core_bus_pkg::core_rsp_t   rsp,
    input  logic                      rsp_ready
);

    localparam int IDX_W = $clog2(SMEM_WORDS);

    core_bus_pkg::data_t mem [SMEM_WORDS];

    logic [IDX_W-1:0] idx;
    logic             req_fire;
    logic             rd_fire;

    assign idx = req.addr[IDX_W-1:0];

    // Stall while a held response cannot leave
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;
    assign rd_fire   = req_fire && !req.write;

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (rd_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire && req.write) begin
            mem[idx] <= req.data;
        end
        if (rd_fire) begin
            rsp <= '{data: mem[idx], tag: req.tag};
        end
    end

endmodule

// File: smem_split.sv
`timescale 1ns/100ps

module smem_split #(
    parameter int SMEM_WORDS = 64
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      dcache_req_valid,
    input  core_bus_pkg::dcache_req_t dcache_req,
    output logic                      dcache_req_ready,
    output logic                      dcache_rsp_valid,
    output core_bus_pkg::core_rsp_t   dcache_rsp,
    input  logic                      dcache_rsp_ready,
    output logic                      mem_req_valid,
    output mem_bus_pkg::mem_req_t     mem_req,
    input  logic                      mem_req_ready,
    input  logic                      mem_rsp_valid,
    input  mem_bus_pkg::mem_rsp_t     mem_rsp,
    output logic                      mem_rsp_ready
);

    logic                    is_smem;
    logic                    smem_req_valid;
    logic                    smem_req_ready;
    logic                    smem_rsp_valid;
    core_bus_pkg::core_rsp_t smem_rsp;
    logic                    smem_rsp_ready;

    // Top address bit selects the scratchpad
    assign is_smem = dcache_req.addr[core_bus_pkg::ADDR_W-1];

    assign smem_req_valid   = dcache_req_valid && is_smem;
    assign mem_req_valid    = dcache_req_valid && !is_smem;
    assign dcache_req_ready = is_smem ? smem_req_ready : mem_req_ready;

    always_comb begin
        mem_req              = '0;
        mem_req.write        = dcache_req.write;
        mem_req.addr         = dcache_req.addr;
        mem_req.data         = dcache_req.data;
        mem_req.tag.data.src = mem_bus_pkg::SRC_DATA;
        mem_req.tag.data.tag = dcache_req.tag;
    end

    shared_mem #(
        .SMEM_WORDS (SMEM_WORDS)
    ) smem (
        .clk       (clk),
        .reset     (reset),
        .req_valid (smem_req_valid),
        .req       (dcache_req),
        .req_ready (smem_req_ready),
        .rsp_valid (smem_rsp_valid),
        .rsp       (smem_rsp),
        .rsp_ready (smem_rsp_ready)
    );

    // Scratchpad response wins, memory waits
    assign dcache_rsp_valid = smem_rsp_valid || mem_rsp_valid;
    assign smem_rsp_ready   = dcache_rsp_ready;
    assign mem_rsp_ready    = dcache_rsp_ready && !smem_rsp_valid;

    always_comb begin
        if (smem_rsp_valid) begin
            dcache_rsp = smem_rsp;
        end else begin
            dcache_rsp = '{data: mem_rsp.data, tag: mem_rsp.tag.data.tag};
        end
    end

    // Arbiter must only route data-side responses here
    assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid |-> mem_rsp.tag.data.src == mem_bus_pkg::SRC_DATA)
        else $error("smem_split: memory response with wrong source");

endmodule

// File: mem_arb.sv
`timescale 1ns/100ps

module mem_arb (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  icache_mem_req_valid,
    input  mem_bus_pkg::mem_req_t icache_mem_req,
    output logic                  icache_mem_req_ready,
    input  logic                  data_mem_req_valid,
    input  mem_bus_pkg::mem_req_t data_mem_req,
    output logic                  data_mem_req_ready,
    output logic                  icache_mem_rsp_valid,
    output mem_bus_pkg::mem_rsp_t icache_mem_rsp,
    input  logic                  icache_mem_rsp_ready,
    output logic                  data_mem_rsp_valid,
    output mem_bus_pkg::mem_rsp_t data_mem_rsp,
    input  logic                  data_mem_rsp_ready,
    output logic                  mem_req_valid,
    output mem_bus_pkg::mem_req_t mem_req,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    input  mem_bus_pkg::mem_rsp_t mem_rsp,
    output logic                  mem_rsp_ready
);

    // 1 selects the data side
    logic prio;
    logic locked;
    logic locked_sel;
    logic sel;
    logic rsp_src;

    always_comb begin
        if (locked) begin
            sel = locked_sel;
        end else if (icache_mem_req_valid && data_mem_req_valid) begin
            sel = prio;
        end else begin
            sel = data_mem_req_valid;
        end
    end

    assign mem_req_valid        = sel ? data_mem_req_valid : icache_mem_req_valid;
    assign mem_req              = sel ? data_mem_req : icache_mem_req;
    assign icache_mem_req_ready = mem_req_ready && !sel;
    assign data_mem_req_ready   = mem_req_ready && sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            prio       <= 1'b0;
            locked     <= 1'b0;
            locked_sel <= 1'b0;
        end else if (mem_req_valid && mem_req_ready) begin
            locked <= 1'b0;
            prio   <= !sel;
        end else if (mem_req_valid) begin
            // Hold the grant across a memory stall
            locked     <= 1'b1;
            locked_sel <= sel;
        end
    end

    // Source bit sits at the same place in both tag views
    assign rsp_src = mem_rsp.tag.icache.src;

    assign icache_mem_rsp_valid = mem_rsp_valid && (rsp_src == mem_bus_pkg::SRC_ICACHE);
    assign data_mem_rsp_valid   = mem_rsp_valid && (rsp_src == mem_bus_pkg::SRC_DATA);
    assign icache_mem_rsp       = mem_rsp;
    assign data_mem_rsp         = mem_rsp;
    assign mem_rsp_ready        = (rsp_src == mem_bus_pkg::SRC_DATA) ? data_mem_rsp_ready
                                                                     : icache_mem_rsp_ready;

    assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && (mem_req == $past(mem_req)))
        else $error("mem_arb: granted request dropped before acceptance");

endmodule

// File: mem_unit.sv
`timescale 1ns/100ps

module mem_unit #(
    parameter int ICACHE_LINES = 16,
    parameter int SMEM_WORDS   = 64
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      icache_req_valid,
    input  core_bus_pkg::icache_req_t icache_req,
    output logic                      icache_req_ready,
    output logic                      icache_rsp_valid,
    output core_bus_pkg::core_rsp_t   icache_rsp,
    input  logic                      icache_rsp_ready,
    input  logic                      dcache_req_valid,
    input  core_bus_pkg::dcache_req_t dcache_req,
    output logic                      dcache_req_ready,
    output logic                      dcache_rsp_valid,
    output core_bus_pkg::core_rsp_t   dcache_rsp,
    input  logic                      dcache_rsp_ready,
    output logic                      mem_req_valid,
    output mem_bus_pkg::mem_req_t     mem_req,
    input  logic                      mem_req_ready,
    input  logic                      mem_rsp_valid,
    input  mem_bus_pkg::mem_rsp_t     mem_rsp,
    output logic                      mem_rsp_ready
);

    logic                  icache_mem_req_valid;
    mem_bus_pkg::mem_req_t icache_mem_req;
    logic                  icache_mem_req_ready;
    logic                  icache_mem_rsp_valid;
    mem_bus_pkg::mem_rsp_t icache_mem_rsp;
    logic                  icache_mem_rsp_ready;
    logic                  data_mem_req_valid;
    mem_bus_pkg::mem_req_t data_mem_req;
    logic                  data_mem_req_ready;
    logic                  data_mem_rsp_valid;
    mem_bus_pkg::mem_rsp_t data_mem_rsp;
    logic                  data_mem_rsp_ready;

    icache #(
        .ICACHE_LINES (ICACHE_LINES)
    ) icache (
        .clk              (clk),
        .reset            (reset),
        .icache_req_valid (icache_req_valid),
        .icache_req       (icache_req),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp       (icache_rsp),
        .icache_rsp_ready (icache_rsp_ready),
        .mem_req_valid    (icache_mem_req_valid),
        .mem_req          (icache_mem_req),
        .mem_req_ready    (icache_mem_req_ready),
        .mem_rsp_valid    (icache_mem_rsp_valid),
        .mem_rsp          (icache_mem_rsp),
        .mem_rsp_ready    (icache_mem_rsp_ready)
    );

    smem_split #(
        .SMEM_WORDS (SMEM_WORDS)
    ) smem_split (
        .clk              (clk),
        .reset            (reset),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req       (dcache_req),
        .dcache_req_ready (dcache_req_ready),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp       (dcache_rsp),
        .dcache_rsp_ready (dcache_rsp_ready),
        .mem_req_valid    (data_mem_req_valid),
        .mem_req          (data_mem_req),
        .mem_req_ready    (data_mem_req_ready),
        .mem_rsp_valid    (data_mem_rsp_valid),
        .mem_rsp          (data_mem_rsp),
        .mem_rsp_ready    (data_mem_rsp_ready)
    );

    mem_arb mem_arb (
        .clk                  (clk),
        .reset                (reset),
        .icache_mem_req_valid (icache_mem_req_valid),
        .icache_mem_req       (icache_mem_req),
        .icache_mem_req_ready (icache_mem_req_ready),
        .data_mem_req_valid   (data_mem_req_valid),
        .data_mem_req         (data_mem_req),
        .data_mem_req_ready   (data_mem_req_ready),
        .icache_mem_rsp_valid (icache_mem_rsp_valid),
        .icache_mem_rsp       (icache_mem_rsp),
        .icache_mem_rsp_ready (icache_mem_rsp_ready),
        .data_mem_rsp_valid   (data_mem_rsp_valid),
        .data_mem_rsp         (data_mem_rsp),
        .data_mem_rsp_ready   (data_mem_rsp_ready),
        .mem_req_valid        (mem_req_valid),
        .mem_req              (mem_req),
        .mem_req_ready        (mem_req_ready),
        .mem_rsp_valid        (mem_rsp_valid),
        .mem_rsp              (mem_rsp),
        .mem_rsp_ready        (mem_rsp_ready)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: tb_mem_model.sv
`timescale 1ns/100ps

module tb_mem_model (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic [2:0]            lat,
    input  logic                  mem_req_valid,
    input  mem_bus_pkg::mem_req_t mem_req,
    output logic                  mem_req_ready,
    output logic                  mem_rsp_valid,
    output mem_bus_pkg::mem_rsp_t mem_rsp,
    input  logic                  mem_rsp_ready
);

    // Filled from the testbench before reset ends
    core_bus_pkg::data_t mem [65536];

    mem_bus_pkg::mem_rsp_t rsp_q [$];
    int                    due_q [$];
    int                    cycle;

    assign mem_req_ready = !reset && !stall;

    initial begin
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        cycle         = 0;
    end

    always @(posedge clk) begin
        if (reset) begin
            rsp_q.delete();
            due_q.delete();
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(rsp_q.pop_front());
                void'(due_q.pop_front());
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.write) begin
                    mem[mem_req.addr] = mem_req.data;
                end else begin
                    rsp_q.push_back('{data: mem[mem_req.addr], tag: mem_req.tag});
                    due_q.push_back(cycle + int'(lat) - 1);
                end
            end
        end
    end

    // In order, head shown once its latency is over
    always @(negedge clk) begin
        if (!reset && rsp_q.size() > 0 && cycle >= due_q[0]) begin
            mem_rsp_valid = 1'b1;
            mem_rsp       = rsp_q[0];
        end else begin
            mem_rsp_valid = 1'b0;
            mem_rsp       = '0;
        end
    end

endmodule

// File: tb_mem_unit.sv
`timescale 1ns/100ps

module tb_mem_unit;

    localparam int N_DIRECTED = 16;
    localparam int N_FETCH    = 60;
    localparam int N_DATA     = 80;
    localparam int N_TXN      = N_DIRECTED + N_FETCH + N_DATA;
    localparam int TIMEOUT    = 20 * N_TXN + 500;

    logic                      clk;
    logic                      reset;
    logic                      icache_req_valid;
    core_bus_pkg::icache_req_t icache_req;
    logic                      icache_req_ready;
    logic                      icache_rsp_valid;
    core_bus_pkg::core_rsp_t   icache_rsp;
    logic                      icache_rsp_ready;
    logic                      dcache_req_valid;
    core_bus_pkg::dcache_req_t dcache_req;
    logic                      dcache_req_ready;
    logic                      dcache_rsp_valid;
    core_bus_pkg::core_rsp_t   dcache_rsp;
    logic                      dcache_rsp_ready;
    logic                      mem_req_valid;
    mem_bus_pkg::mem_req_t     mem_req;
    logic                      mem_req_ready;
    logic                      mem_rsp_valid;
    mem_bus_pkg::mem_rsp_t     mem_rsp;
    logic                      mem_rsp_ready;
    logic                      mem_stall;
    logic [2:0]                mem_lat;

    core_bus_pkg::core_rsp_t   icache_exp [$];
    core_bus_pkg::data_t       data_exp [16];
    logic [15:0]               busy;
    core_bus_pkg::data_t       smem_shadow [64];
    core_bus_pkg::data_t       ext_shadow [logic [15:0]];
    logic [15:0]               fetch_addr [N_FETCH];
    core_bus_pkg::dcache_req_t data_list [N_DATA];
    logic [3:0]                fetch_tag;
    logic [31:0]               rng_state;
    logic [31:0]               rnd;
    int                        cycles;

    tb_clock_gen clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    mem_unit #(
        .ICACHE_LINES (16),
        .SMEM_WORDS   (64)
    ) dut (
        .clk              (clk),
        .reset            (reset),
        .icache_req_valid (icache_req_valid),
        .icache_req       (icache_req),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp       (icache_rsp),
        .icache_rsp_ready (icache_rsp_ready),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req       (dcache_req),
        .dcache_req_ready (dcache_req_ready),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp       (dcache_rsp),
        .dcache_rsp_ready (dcache_rsp_ready),
        .mem_req_valid    (mem_req_valid),
        .mem_req          (mem_req),
        .mem_req_ready    (mem_req_ready),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp          (mem_rsp),
        .mem_rsp_ready    (mem_rsp_ready)
    );

    tb_mem_model mem_model (
        .clk           (clk),
        .reset         (reset),
        .stall         (mem_stall),
        .lat           (mem_lat),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return {16'h0, rng_state[30:15]};
    endfunction

    // Initial contents of external memory
    function automatic logic [31:0] ref_word(input logic [15:0] addr);
        logic [31:0] w;
        w = {16'h0, addr} * 32'h9E3779B1;
        return w ^ {addr, ~addr};
    endfunction

    function automatic logic [31:0] ext_word(input logic [15:0] addr);
        if (ext_shadow.exists(addr)) begin
            return ext_shadow[addr];
        end
        return ref_word(addr);
    endfunction

    function automatic int free_tag();
        for (int i = 0; i < 16; i++) begin
            if (!busy[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic fail_run(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    // Called at a falling edge, returns at a falling edge
    task automatic send_fetch(input logic [15:0] addr);
        icache_req_valid = 1'b1;
        icache_req       = '{addr: addr, tag: fetch_tag};
        fetch_tag        = fetch_tag + 4'd1;
        @(posedge clk);
        while (!(icache_req_valid && icache_req_ready)) @(posedge clk);
        @(negedge clk);
        icache_req_valid = 1'b0;
    endtask

    task automatic send_data(input logic write, input logic [15:0] addr, input logic [31:0] data);
        int t;
        t = 0;
        if (!write) begin
            t = free_tag();
            while (t < 0) begin
                @(negedge clk);
                t = free_tag();
            end
        end
        dcache_req_valid = 1'b1;
        dcache_req       = '{write: write, addr: addr, data: data, tag: 4'(t)};
        @(posedge clk);
        while (!(dcache_req_valid && dcache_req_ready)) @(posedge clk);
        @(negedge clk);
        dcache_req_valid = 1'b0;
    endtask

    // Ready and memory timing change every cycle
    always @(negedge clk) begin
        rnd              = next_rand();
        mem_stall        = (rnd[1:0] == 2'd0);
        mem_lat          = 3'd1 + (rnd[4:2] % 3'd6);
        icache_rsp_ready = (rnd[6:5] != 2'd0);
        dcache_rsp_ready = (rnd[8:7] != 2'd0);
    end

    // Comparison and expected values
    always @(posedge clk) begin
        core_bus_pkg::core_rsp_t exp;
        if (!reset) begin
            cycles = cycles + 1;
            if (cycles > TIMEOUT) begin
                fail_run("timeout, responses still missing");
            end
            if (mem_req_valid) begin
                check(64'(mem_req.addr[15]), 64'(0), "scratchpad access on memory channel");
            end
            if (icache_rsp_valid && icache_rsp_ready) begin
                if (icache_exp.size() == 0) begin
                    fail_run("instruction response with no fetch pending");
                end else begin
                    exp = icache_exp.pop_front();
                    check(64'(icache_rsp.data), 64'(exp.data), "instruction data");
                    check(64'(icache_rsp.tag), 64'(exp.tag), "instruction tag");
                end
            end
            if (dcache_rsp_valid && dcache_rsp_ready) begin
                if (!busy[dcache_rsp.tag]) begin
                    fail_run("data response for a tag with no read pending");
                end else begin
                    check(64'(dcache_rsp.data), 64'(data_exp[dcache_rsp.tag]), "data read");
                    busy[dcache_rsp.tag] = 1'b0;
                end
            end
            if (icache_req_valid && icache_req_ready) begin
                icache_exp.push_back('{data: ref_word(icache_req.addr), tag: icache_req.tag});
            end
            if (dcache_req_valid && dcache_req_ready) begin
                if (dcache_req.write && dcache_req.addr[15]) begin
                    smem_shadow[dcache_req.addr[5:0]] = dcache_req.data;
                end else if (dcache_req.write) begin
                    ext_shadow[dcache_req.addr] = dcache_req.data;
                end else begin
                    busy[dcache_req.tag] = 1'b1;
                    data_exp[dcache_req.tag] = dcache_req.addr[15]
                        ? smem_shadow[dcache_req.addr[5:0]] : ext_word(dcache_req.addr);
                end
            end
        end
    end

    initial begin
        logic [63:0] written;
        logic [31:0] r;
        logic [15:0] a;
        logic [31:0] d;
        icache_req_valid = 1'b0;
        icache_req       = '0;
        icache_rsp_ready = 1'b0;
        dcache_req_valid = 1'b0;
        dcache_req       = '0;
        dcache_rsp_ready = 1'b0;
        mem_stall        = 1'b0;
        mem_lat          = 3'd1;
        rng_state        = 32'd6458;
        busy             = '0;
        fetch_tag        = '0;
        cycles           = 0;
        written          = '0;
        for (int i = 0; i < 65536; i++) begin
            mem_model.mem[i] = ref_word(16'(i));
        end

        for (int i = 0; i < N_FETCH; i++) begin
            r = next_rand();
            fetch_addr[i] = 16'h4000 | (r[15:0] & 16'h003F);
        end
        // Scratchpad reads only hit words already written
        for (int i = 0; i < N_DATA; i++) begin
            r = next_rand();
            a = 16'(next_rand());
            d = (next_rand() << 16) ^ next_rand();
            data_list[i] = '{write: 1'b1, addr: 16'h8000 | (a & 16'h7FFF), data: d, tag: '0};
            case (r[1:0])
                2'd1: data_list[i].write = !written[a[5:0]];
                2'd2: data_list[i].addr = a & 16'h003F;
                2'd3: begin
                    data_list[i].write = 1'b0;
                    data_list[i].addr  = a & 16'h403F;
                end
                default: ;
            endcase
            if (data_list[i].write && data_list[i].addr[15]) begin
                written[a[5:0]] = 1'b1;
            end
        end

        while (reset !== 1'b0) @(negedge clk);
        @(negedge clk);

        // Miss, hit, conflicting line, refill
        send_fetch(16'h4005);
        send_fetch(16'h4005);
        send_fetch(16'h4015);
        send_fetch(16'h4005);
        send_data(1'b1, 16'h8003, 32'hCAFE0001);
        send_data(1'b0, 16'h8003, 32'h0);
        send_data(1'b1, 16'h0123, 32'h12345678);
        send_data(1'b0, 16'h0123, 32'h0);
        for (int i = 0; i < 8; i++) begin
            send_data(1'b0, 16'h0200 + 16'(i), 32'h0);
        end

        fork
            begin
                for (int i = 0; i < N_FETCH; i++) begin
                    send_fetch(fetch_addr[i]);
                end
            end
            begin
                for (int i = 0; i < N_DATA; i++) begin
                    send_data(data_list[i].write, data_list[i].addr, data_list[i].data);
                end
            end
        join

        while (icache_exp.size() != 0 || busy != 16'h0) @(negedge clk);
        repeat (5) @(negedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: mem_unit.f
core_bus_pkg.sv
mem_bus_pkg.sv
icache.sv
shared_mem.sv
smem_split.sv
mem_arb.sv
mem_unit.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_mem_unit.sv

// File: run.sh
#!/bin/sh
# Build and run the mem_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mem_unit.f --top-module tb_mem_unit -o sim_mem_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_mem_unit 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "Pass message not found"
exit 1
